// ==== tb.f ====
verilog/sdram_pkg.sv
verilog/sdram_req_stage.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_sequencer.sv
verilog/sdram_phy.sv
verilog/sdram_ctrl_top.sv
tests/sdram_chip_model.sv
tests/tb_sdram_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the SDRAM controller testbench

SIM  := obj_dir/Vtb_sdram_ctrl
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_sdram_ctrl -f tb.f -o Vtb_sdram_ctrl

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Everything OK" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_sdram_ctrl.sv ====
`timescale 1ns/10ps

module tb_sdram_ctrl;
   import sdram_pkg::*;

   localparam int n_ops           = 200;
   localparam int op_limit        = 40;    // cycles allowed per operation
   localparam int watchdog_cycles = n_ops * op_limit + init_cycles + 300;

   logic        CLOCK_100;
   logic        rst;
   waddr_t      address;
   logic        req_read;
   logic        req_write;
   word_t       data_in;
   word_t       data_out;
   logic        data_valid;
   logic        write_complete;
   logic [12:0] dram_addr;
   bank_t       dram_ba;
   logic        dram_cs_n;
   logic        dram_ras_n;
   logic        dram_cas_n;
   logic        dram_we_n;
   logic [1:0]  dram_dqm;
   logic        dram_cke;
   logic        dram_clk;
   wire  [15:0] dram_dq;
   int          chip_errors;
   logic        init_seen;

   int          errors;
   int          n_writes;
   int          n_reads;
   int          wr_pulses;
   int          rd_pulses;
   logic [31:0] rng;
   waddr_t      pool [16];
   word_t       ref_mem [waddr_t];   // keyed by word address with bit 0 cleared

   sdram_ctrl_top dut0 (.*);

   sdram_chip_model chip0 (.*, .err_count(chip_errors), .init_seen(init_seen));

   initial CLOCK_100 = 1'b0;
   always #10 CLOCK_100 = ~CLOCK_100;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   always @(negedge CLOCK_100) begin
      if (write_complete) wr_pulses++;
      if (data_valid) rd_pulses++;
   end

   // one strobe, then wait for its completion pulse
   task automatic run_op(input logic is_write, input waddr_t a, input word_t d);
      word_t       expect_word;
      logic [24:0] key_lo;
      logic [24:0] key_hi;
      int          n;
      expect_word = ref_mem.exists({a[23:1], 1'b0}) ? ref_mem[{a[23:1], 1'b0}] : '0;
      key_lo      = {a[10:9], a[23:11], a[8:1], 2'b00};
      key_hi      = {a[10:9], a[23:11], a[8:1], 2'b01};   // column plus one
      @(negedge CLOCK_100);
      address   = a;
      data_in   = d;
      req_write = is_write;
      req_read  = !is_write;
      @(negedge CLOCK_100);
      req_write = 1'b0;
      req_read  = 1'b0;
      n = 0;
      while (!(is_write ? write_complete : data_valid) && n < op_limit) begin
         @(negedge CLOCK_100);
         n++;
      end
      assert (n < op_limit) else begin
         $display("no completion pulse within %0d cycles for address %h", op_limit, a);
         errors++;
      end
      if (is_write) begin
         n_writes++;
         ref_mem[{a[23:1], 1'b0}] = d;
         assert (chip0.peek(key_lo) == d[15:0] && chip0.peek(key_hi) == d[31:16]) else begin
            $display("Fail %0t: chip holds %h_%h for address %h, expected %h", $time,
                     chip0.peek(key_hi), chip0.peek(key_lo), a, d);
            errors++;
         end
      end else begin
         n_reads++;
         assert (data_out == expect_word) else begin
            $display("Fail %0t: read %h from address %h, expected %h", $time, data_out, a,
                     expect_word);
            errors++;
         end
      end
   endtask

   initial begin
      rst       = 1'b1;
      address   = '0;
      data_in   = '0;
      req_read  = 1'b0;
      req_write = 1'b0;
      errors    = 0;
      n_writes  = 0;
      n_reads   = 0;
      wr_pulses = 0;
      rd_pulses = 0;
      rng       = 32'd16;
      foreach (pool[i]) begin
         rng     = xorshift32(rng);
         pool[i] = rng[23:0];
      end
      repeat (8) @(negedge CLOCK_100);
      rst = 1'b0;
      repeat (init_cycles + 8) @(negedge CLOCK_100);   // power-up sequence
      for (int i = 0; i < n_ops; i++) begin
         logic [31:0] pick;
         rng  = xorshift32(rng);
         pick = rng;
         rng  = xorshift32(rng);
         run_op(pick[8], pool[pick[3:0]], rng);
      end
      repeat (20) @(negedge CLOCK_100);
      assert (wr_pulses == n_writes && rd_pulses == n_reads) else begin
         $display("pulse count off: %0d write_complete for %0d writes, %0d data_valid for %0d reads",
                  wr_pulses, n_writes, rd_pulses, n_reads);
         errors++;
      end
      assert (init_seen) else begin
         $display("the power-up sequence never reached mode register set");
         errors++;
      end
      $display("errors: testbench %0d, chip model %0d", errors, chip_errors);
      if (errors + chip_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(watchdog_cycles * 20);
      $display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
      $display("Something failed");
      $finish;
   end

endmodule

// ==== tests/sdram_chip_model.sv ====
`timescale 1ns/10ps

module sdram_chip_model (
   input  logic        dram_clk,
   input  logic        dram_cke,
   input  logic        dram_cs_n,
   input  logic        dram_ras_n,
   input  logic        dram_cas_n,
   input  logic        dram_we_n,
   input  logic [12:0] dram_addr,
   input  logic [1:0]  dram_ba,
   input  logic [1:0]  dram_dqm,
   inout  wire  [15:0] dram_dq,
   output int          err_count,
   output logic        init_seen
);
   import sdram_pkg::*;

   localparam int chip_cl = 3;   // cas latency of this part
   // cas 3, sequential, burst 1
   localparam logic [12:0] mode_expect = {6'b000000, 3'd3, 1'b0, 3'b000};
   // longest read is act, 2 nops, 2 reads, 2 waits, 2 captures, pre, nop, plus idle
   localparam int longest_seq = 12;
   localparam int max_ref_gap = refresh_interval + 1 + longest_seq + 2;

   logic [15:0] mem [logic [24:0]];          // key is {bank, row, col}
   logic [3:0]  bank_open;
   logic [12:0] row_of [4];
   logic [16:0] rd_pipe [chip_cl - 1];       // {valid, data}
   logic        out_valid;
   logic [15:0] out_data;
   logic        pre_all_seen;
   logic        ref_armed;
   int          init_refs;
   int          since_ref;
   cmd_code_t   code;

   assign code    = {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n};
   assign dram_dq = out_valid ? out_data : 'z;

   // unwritten locations read as zero
   function automatic logic [15:0] peek(input logic [24:0] key);
      return mem.exists(key) ? mem[key] : 16'h0000;
   endfunction

   task automatic flag(input string msg);
      $display("chip model at %0t: %s", $time, msg);
      err_count++;
   endtask

   initial begin
      err_count    = 0;
      init_seen    = 1'b0;
      bank_open    = 4'b0000;
      out_valid    <= 1'b0;
      out_data     <= '0;
      pre_all_seen = 1'b0;
      ref_armed    = 1'b0;
      init_refs    = 0;
      since_ref    = 0;
      foreach (rd_pipe[i]) rd_pipe[i] <= '0;
   end

   always @(posedge dram_clk) begin
      logic [16:0] rd_word;
      rd_word = '0;
      since_ref++;
      assert (!(ref_armed && since_ref == max_ref_gap + 1))
         else flag($sformatf("no refresh for more than %0d cycles", max_ref_gap));
      if (out_valid) begin
         assert (dram_dq === out_data) else flag("bus contention while the chip drives dq");
      end
      if (dram_cke === 1'b1) begin
         case (code)
            cmd_act: begin
               assert (init_seen) else flag("activate before power-up finished");
               assert (!bank_open[dram_ba]) else flag("activate to a bank with an open row");
               bank_open[dram_ba] = 1'b1;
               row_of[dram_ba]    = dram_addr;
            end
            cmd_read: begin
               assert (bank_open[dram_ba]) else flag("read to a bank with no open row");
               assert (dram_dqm == 2'b00) else flag("byte mask set on a read");
               rd_word = {1'b1, peek({dram_ba, row_of[dram_ba], dram_addr[9:0]})};
            end
            cmd_write: begin
               assert (bank_open[dram_ba]) else flag("write to a bank with no open row");
               assert (!out_valid) else flag("write data while the chip drives dq");
               assert (dram_dqm == 2'b00) else flag("byte mask set on a write");
               mem[{dram_ba, row_of[dram_ba], dram_addr[9:0]}] = dram_dq;
            end
            cmd_pre: begin
               if (dram_addr[10]) begin
                  bank_open = 4'b0000;
                  pre_all_seen = pre_all_seen | !init_seen;
               end else begin
                  bank_open[dram_ba] = 1'b0;
               end
            end
            cmd_ref: begin
               assert (bank_open == 4'b0000) else flag("refresh with a bank still open");
               if (!init_seen) begin
                  assert (pre_all_seen) else flag("power-up refresh before precharge-all");
                  init_refs++;
               end
               since_ref = 0;
            end
            cmd_mrs: begin
               assert (pre_all_seen && init_refs == init_refreshes)
                  else flag($sformatf("mode register set after %0d refreshes", init_refs));
               assert (dram_addr == mode_expect)
                  else begin
                     $display("Fail %0t: mode word %h, expected %h", $time, dram_addr,
                              mode_expect);
                     err_count++;
                  end
               init_seen = 1'b1;
               ref_armed = 1'b1;
               since_ref = 0;
            end
            default: ;
         endcase
      end
      // read data goes out chip_cl edges after the command
      out_valid <= rd_pipe[chip_cl - 2][16];
      out_data  <= rd_pipe[chip_cl - 2][15:0];
      for (int i = chip_cl - 2; i > 0; i--) begin
         rd_pipe[i] <= rd_pipe[i - 1];
      end
      rd_pipe[0] <= rd_word;
   end

endmodule

// ==== verilog/sdram_ctrl_top.sv ====
`timescale 1ns/10ps

module sdram_ctrl_top (
   input  logic              CLOCK_100,
   input  logic              rst,
   input  sdram_pkg::waddr_t address,
   input  logic              req_read,
   input  logic              req_write,
   input  sdram_pkg::word_t  data_in,
   output sdram_pkg::word_t  data_out,
   output logic              data_valid,
   output logic              write_complete,
   output logic [12:0]       dram_addr,
   output sdram_pkg::bank_t  dram_ba,
   output logic              dram_cs_n,
   output logic              dram_ras_n,
   output logic              dram_cas_n,
   output logic              dram_we_n,
   output logic [1:0]        dram_dqm,
   output logic              dram_cke,
   output logic              dram_clk,
   inout  wire  [15:0]       dram_dq
);
   import sdram_pkg::*;

   sdram_req_t req;
   logic       req_valid;
   logic       req_take;
   logic       rf_due;
   logic       rf_ack;
   logic       init_done;
   sdram_cmd_t cmd;

   sdram_req_stage req0 (
      .CLOCK_100 (CLOCK_100),
      .rst       (rst),
      .address   (address),
      .req_read  (req_read),
      .req_write (req_write),
      .data_in   (data_in),
      .req_take  (req_take),
      .req       (req),
      .req_valid (req_valid)
   );

   sdram_refresh_timer rft0 (
      .CLOCK_100 (CLOCK_100),
      .rst       (rst),
      .run       (init_done),    // periodic refresh starts after power-up
      .rf_ack    (rf_ack),
      .rf_due    (rf_due)
   );

   sdram_sequencer seq0 (
      .CLOCK_100 (CLOCK_100),
      .rst       (rst),
      .req       (req),
      .req_valid (req_valid),
      .req_take  (req_take),
      .rf_due    (rf_due),
      .rf_ack    (rf_ack),
      .init_done (init_done),
      .cmd       (cmd)
   );

   sdram_phy phy0 (
      .CLOCK_100      (CLOCK_100),
      .rst            (rst),
      .cmd            (cmd),
      .dram_addr      (dram_addr),
      .dram_ba        (dram_ba),
      .dram_cs_n      (dram_cs_n),
      .dram_ras_n     (dram_ras_n),
      .dram_cas_n     (dram_cas_n),
      .dram_we_n      (dram_we_n),
      .dram_dqm       (dram_dqm),
      .dram_cke       (dram_cke),
      .dram_clk       (dram_clk),
      .dram_dq        (dram_dq),
      .data_out       (data_out),
      .data_valid     (data_valid),
      .write_complete (write_complete)
   );

endmodule

// ==== verilog/sdram_phy.sv ====
`timescale 1ns/10ps

module sdram_phy (
   input  logic                  CLOCK_100,
   input  logic                  rst,
   input  sdram_pkg::sdram_cmd_t cmd,
   output logic [12:0]           dram_addr,
   output sdram_pkg::bank_t      dram_ba,
   output logic                  dram_cs_n,
   output logic                  dram_ras_n,
   output logic                  dram_cas_n,
   output logic                  dram_we_n,
   output logic [1:0]            dram_dqm,
   output logic                  dram_cke,
   output logic                  dram_clk,
   inout  wire  [15:0]           dram_dq,
   output sdram_pkg::word_t      data_out,
   output logic                  data_valid,
   output logic                  write_complete
);
   import sdram_pkg::*;

   logic  dq_oe_q;
   half_t dq_out_q;

   assign dram_clk = CLOCK_100;
   assign dram_dqm = 2'b00;                        // no byte masking
   assign dram_dq  = dq_oe_q ? dq_out_q : 'z;

   always_ff @(posedge CLOCK_100) begin
      if (rst) begin
         {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} <= cmd_nop;
         dq_oe_q        <= 1'b0;
         dram_cke       <= 1'b0;
         data_valid     <= 1'b0;
         write_complete <= 1'b0;
      end else begin
         {dram_cs_n, dram_ras_n, dram_cas_n, dram_we_n} <= cmd.cmd;
         dq_oe_q        <= cmd.dq_oe;
         dram_cke       <= 1'b1;
         data_valid     <= cmd.rd_done;            // same word as cap_hi
         write_complete <= cmd.wr_done;
      end
   end

   always_ff @(posedge CLOCK_100) begin
      dram_addr <= cmd.addr;
      dram_ba   <= cmd.ba;
      dq_out_q  <= cmd.dq_out;
      if (cmd.cap_lo) begin
         data_out[15:0] <= dram_dq;
      end
      if (cmd.cap_hi) begin
         data_out[31:16] <= dram_dq;
      end
   end

   // bus must be released before and while the chip drives read data
   a_no_drive_on_capture: assert property (
      @(posedge CLOCK_100) disable iff (rst)
      (cmd.cap_lo || cmd.cap_hi) |-> !cmd.dq_oe && !dq_oe_q)
      else $error("phy: dq driven while a read half is captured");

endmodule

// ==== verilog/sdram_sequencer.sv ====
`timescale 1ns/10ps

module sdram_sequencer (
   input  logic                  CLOCK_100,
   input  logic                  rst,
   input  sdram_pkg::sdram_req_t req,
   input  logic                  req_valid,
   output logic                  req_take,
   input  logic                  rf_due,
   output logic                  rf_ack,
   output logic                  init_done,
   output sdram_pkg::sdram_cmd_t cmd
);
   import sdram_pkg::*;

   typedef enum logic [4:0] {
      s_init,
      s_idle,
      s_ref,
      s_ref_wait,
      s_act,
      s_act_wait,
      s_wr_lo,
      s_wr_hi,
      s_wr_rec,
      s_wr_pre,
      s_wr_end,
      s_rd_lo,
      s_rd_hi,
      s_rd_wait,
      s_rd_cap_lo,
      s_rd_cap_hi,
      s_rd_pre,
      s_rd_end
   } state_t;

   state_t      state;
   logic [7:0]  init_cnt;     // counts down through power-up
   logic [2:0]  wait_cnt;     // remaining nops in a wait state
   sdram_req_t  cur;          // request being served
   logic [12:0] col_addr_lo;
   logic [12:0] col_addr_hi;

   // where each wait state goes once its nops are done
   function automatic state_t after_wait(state_t s, logic is_write);
      case (s)
         s_act_wait: return is_write ? s_wr_lo : s_rd_lo;
         s_wr_rec:   return s_wr_pre;
         s_rd_wait:  return s_rd_cap_lo;
         default:    return s_idle;
      endcase
   endfunction

   assign init_done   = (state != s_init);
   assign col_addr_lo = {3'b000, cur.col};               // a10 low, no auto precharge
   assign col_addr_hi = {3'b000, cur.col + col_t'(1)};

   always_ff @(posedge CLOCK_100) begin
      if (rst) begin
         state    <= s_init;
         init_cnt <= 8'(init_cycles - 1);
         wait_cnt <= '0;
      end else begin
         case (state)
            s_init: begin
               init_cnt <= init_cnt - 1'b1;
               if (init_cnt == 8'd0) begin
                  state <= s_idle;
               end
            end
            s_idle: begin
               if (rf_due) begin            // refresh wins over a held request
                  state <= s_ref;
               end else if (req_valid) begin
                  state <= s_act;
               end
            end
            s_ref: begin
               state    <= s_ref_wait;
               wait_cnt <= 3'(t_rfc_wait - 1);
            end
            s_act: begin
               state    <= s_act_wait;
               wait_cnt <= 3'(t_rcd_wait - 1);
            end
            s_ref_wait, s_act_wait, s_wr_rec, s_rd_wait: begin
               if (wait_cnt != 3'd0) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else begin
                  state <= after_wait(state, cur.is_write);
               end
            end
            s_wr_lo: state <= s_wr_hi;
            s_wr_hi: begin
               state    <= s_wr_rec;
               wait_cnt <= 3'd1;            // two write recovery nops
            end
            s_wr_pre: state <= s_wr_end;
            s_rd_lo:  state <= s_rd_hi;
            s_rd_hi: begin
               // first half lands cas_latency + 1 words after rd_lo,
               // the extra one being the pin register
               state    <= s_rd_wait;
               wait_cnt <= 3'(cas_latency - 2);
            end
            s_rd_cap_lo: state <= s_rd_cap_hi;
            s_rd_cap_hi: state <= s_rd_pre;
            s_rd_pre:    state <= s_rd_end;
            default:     state <= s_idle;   // s_wr_end, s_rd_end
         endcase
      end
   end

   always_ff @(posedge CLOCK_100) begin
      if (req_take) begin
         cur <= req;
      end
   end

   always_comb begin
      cmd      = '0;
      cmd.cmd  = cmd_nop;
      req_take = 1'b0;
      rf_ack   = 1'b0;
      case (state)
         s_init: begin
            if (init_cnt == 8'(init_refreshes * 16 + 2)) begin
               cmd.cmd      = cmd_pre;
               cmd.addr[10] = 1'b1;         // all banks
            end else if (init_cnt < 8'(init_refreshes * 16) && init_cnt[3:0] == 4'hf) begin
               cmd.cmd = cmd_ref;           // every 16 cycles
            end else if (init_cnt == 8'd2) begin
               cmd.cmd  = cmd_mrs;
               cmd.addr = mode_word;
            end
         end
         s_ref: begin
            cmd.cmd = cmd_ref;
            rf_ack  = 1'b1;
         end
         s_act: begin
            cmd.cmd  = cmd_act;
            cmd.addr = req.row;
            cmd.ba   = req.bank;
            req_take = 1'b1;
         end
         s_wr_lo: begin
            cmd.cmd    = cmd_write;
            cmd.addr   = col_addr_lo;
            cmd.ba     = cur.bank;
            cmd.dq_oe  = 1'b1;
            cmd.dq_out = cur.wdata[15:0];
         end
         s_wr_hi: begin
            cmd.cmd    = cmd_write;
            cmd.addr   = col_addr_hi;
            cmd.ba     = cur.bank;
            cmd.dq_oe  = 1'b1;
            cmd.dq_out = cur.wdata[31:16];
         end
         s_wr_pre, s_rd_pre: begin
            cmd.cmd = cmd_pre;              // a10 low, this bank only
            cmd.ba  = cur.bank;
         end
         s_wr_end: cmd.wr_done = 1'b1;
         s_rd_lo: begin
            cmd.cmd  = cmd_read;
            cmd.addr = col_addr_lo;
            cmd.ba   = cur.bank;
         end
         s_rd_hi: begin
            cmd.cmd  = cmd_read;
            cmd.addr = col_addr_hi;
            cmd.ba   = cur.bank;
         end
         s_rd_cap_lo: cmd.cap_lo = 1'b1;
         s_rd_cap_hi: begin
            cmd.cap_hi  = 1'b1;
            cmd.rd_done = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/sdram_refresh_timer.sv ====
`timescale 1ns/10ps

module sdram_refresh_timer (
   input  logic CLOCK_100,
   input  logic rst,
   input  logic run,
   input  logic rf_ack,
   output logic rf_due
);
   import sdram_pkg::*;

   logic [9:0] rf_cnt;

   always_ff @(posedge CLOCK_100) begin
      if (rst) begin
         rf_cnt <= '0;
         rf_due <= 1'b0;
      end else if (rf_cnt == 10'(refresh_interval)) begin
         rf_cnt <= '0;
         rf_due <= 1'b1;
      end else begin
         if (run) begin
            rf_cnt <= rf_cnt + 1'b1;   // stopped during power-up
         end
         if (rf_ack) begin
            rf_due <= 1'b0;
         end
      end
   end

   a_ack_needs_due: assert property (
      @(posedge CLOCK_100) disable iff (rst)
      rf_ack |-> rf_due)
      else $error("refresh timer: refresh issued while none was due");

endmodule

// ==== verilog/sdram_req_stage.sv ====
`timescale 1ns/10ps

module sdram_req_stage (
   input  logic                  CLOCK_100,
   input  logic                  rst,
   input  sdram_pkg::waddr_t     address,
   input  logic                  req_read,
   input  logic                  req_write,
   input  sdram_pkg::word_t      data_in,
   input  logic                  req_take,
   output sdram_pkg::sdram_req_t req,
   output logic                  req_valid
);

   logic strobe;

   assign strobe = req_read | req_write;

   always_ff @(posedge CLOCK_100) begin
      if (rst) begin
         req_valid <= 1'b0;
      end else if (strobe) begin
         req_valid <= 1'b1;
      end else if (req_take) begin
         req_valid <= 1'b0;
      end
   end

   // address split into row / bank / column
   always_ff @(posedge CLOCK_100) begin
      if (strobe) begin
         req.is_write <= req_write;
         req.row      <= address[23:11];
         req.bank     <= address[10:9];
         req.col      <= {address[8:1], 2'b00};   // two halves per word
         req.wdata    <= data_in;
      end
   end

   // only one request may be outstanding
   a_no_strobe_while_held: assert property (
      @(posedge CLOCK_100) disable iff (rst)
      req_valid |-> !strobe)
      else $error("request stage: strobe while a request is still held");

   a_single_strobe: assert property (
      @(posedge CLOCK_100) disable iff (rst)
      !(req_read && req_write))
      else $error("request stage: read and write strobe in the same cycle");

   // the sequencer only takes what is held
   a_take_needs_valid: assert property (
      @(posedge CLOCK_100) disable iff (rst)
      req_take |-> req_valid)
      else $error("request stage: take without a held request");

endmodule

// ==== verilog/sdram_pkg.sv ====
package sdram_pkg;

   typedef logic [23:0] waddr_t;     // user word address
   typedef logic [31:0] word_t;
   typedef logic [15:0] half_t;      // one beat on dq
   typedef logic [12:0] row_t;
   typedef logic [1:0]  bank_t;
   typedef logic [9:0]  col_t;
   typedef logic [3:0]  cmd_code_t;  // {cs_n, ras_n, cas_n, we_n}

   // SDRAM truth table
   localparam cmd_code_t cmd_nop   = 4'b0111;
   localparam cmd_code_t cmd_read  = 4'b0101;
   localparam cmd_code_t cmd_write = 4'b0100;
   localparam cmd_code_t cmd_act   = 4'b0011;
   localparam cmd_code_t cmd_pre   = 4'b0010;
   localparam cmd_code_t cmd_ref   = 4'b0001;
   localparam cmd_code_t cmd_mrs   = 4'b0000;

   localparam int cas_latency      = 3;
   localparam int t_rcd_wait       = 2;    // nops after activate
   localparam int t_rfc_wait       = 5;    // nops after refresh
   localparam int refresh_interval = 770;
   localparam int init_cycles      = 143;
   localparam int init_refreshes   = 8;

   // reserved, write burst as programmed, normal op, cas 3, sequential, burst 1
   localparam logic [12:0] mode_word = 13'b000_0_00_011_0_000;

   typedef struct packed {
      logic  is_write;
      row_t  row;
      bank_t bank;
      col_t  col;     // low half column, high half at col + 1
      word_t wdata;
   } sdram_req_t;

   // one word per cycle from the sequencer to the pin stage
   typedef struct packed {
      cmd_code_t   cmd;
      logic [12:0] addr;
      bank_t       ba;
      logic        dq_oe;     // drive dq with dq_out
      half_t       dq_out;
      logic        cap_lo;    // sample dq into data_out low half
      logic        cap_hi;
      logic        wr_done;
      logic        rd_done;
   } sdram_cmd_t;

endpackage
